// File: design/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "pov_macros.svh"

module cmd_decoder import spi_pkg::*, pixel_pkg::*; (
   input  wire logic clk,
   input  wire logic nrst,
   spi_cmd_if.rx     cmd,
   output rotation_t    rotation,
   output driver_conf_t driver_conf,
   output logic         new_config,
   output logic         rgb_enable,
   output ram_addr_t    read_addr
);

   cmd_len_t req_len;
   logic     known_op;
   logic     accept;

   // Required payload length per opcode
   always_comb begin
      known_op = 1'b1;
      req_len  = '0;
      case (cmd.opcode)
         op_rotation: begin
            req_len = cmd_len_t'(`POV_LEN_ROTATION);
         end
         op_driver_conf: begin
            req_len = cmd_len_t'(`POV_LEN_DRIVER_CONF);
         end
         op_rgb_enable: begin
            req_len = cmd_len_t'(`POV_LEN_RGB_ENABLE);
         end
         op_read_addr: begin
            req_len = cmd_len_t'(`POV_LEN_READ_ADDR);
         end
         default: begin
            known_op = 1'b0;
         end
      endcase
   end

   // Wrong length or unknown opcode leaves the state alone
   assign accept = cmd.valid & known_op & (cmd.len == req_len);

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         rotation    <= '0;
         driver_conf <= '0;
         new_config  <= 1'b0;
         rgb_enable  <= 1'b0;
         read_addr   <= '0;
      end else begin
         // Pulse by default low
         new_config <= 1'b0;
         if (accept) begin
            case (cmd.opcode)
               op_rotation: begin
                  rotation <= cmd.payload[47:32];
               end
               op_driver_conf: begin
                  driver_conf <= cmd.payload;
                  new_config  <= 1'b1;
               end
               op_rgb_enable: begin
                  // LSB of the single payload byte
                  rgb_enable <= cmd.payload[40];
               end
               op_read_addr: begin
                  read_addr <= cmd.payload[47:32];
               end
               default: begin
                  rotation <= rotation;
               end
            endcase
         end
      end
   end

   // Back-to-back config frames are far apart, so no double pulse
   a_new_config_pulse: assert property (@(posedge clk) disable iff (!nrst)
      new_config |=> !new_config);

endmodule

`default_nettype wire

// File: design/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pov_macros.svh"

module frame_ram import pixel_pkg::*; (
   input  wire logic clk,
   input  wire logic wr_en,
   input  ram_addr_t wr_addr,
   input  rgb565_t   wr_data,
   input  ram_addr_t rd_addr,
   output rgb565_t   rd_data
);

   // Full address space, one RGB565 word per cell
   rgb565_t mem [2**`POV_RAM_AW];

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read port, one cycle latency like block RAM
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: design/pixel_pkg.sv
`default_nettype none

`include "pov_macros.svh"

package pixel_pkg;

   // Video input pixel, red in the top byte
   typedef logic [23:0] rgb888_t;

   // Stored pixel, 5-6-5 packing
   typedef logic [15:0] rgb565_t;

   // Frame RAM address
   typedef logic [`POV_RAM_AW-1:0] ram_addr_t;

   // Pixel counter within a frame
   // One extra bit so the count can reach POV_FRAME_PIXELS
   typedef logic [$clog2(`POV_FRAME_PIXELS):0] pix_cnt_t;

endpackage

`default_nettype wire

// File: design/pov_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pov_ctrl_top import spi_pkg::*, pixel_pkg::*; (
   input  wire logic    clk,
   input  wire logic    nrst,
   // Host SPI
   input  wire logic    som_sclk,
   input  wire logic    som_cs_n,
   input  wire logic    som_mosi,
   output logic         som_miso,
   // Video input
   input  rgb888_t      rgb_d,
   input  wire logic    rgb_de,
   input  wire logic    rgb_vsync,
   // Display state
   output rotation_t    rotation,
   output driver_conf_t driver_conf,
   output logic         new_config,
   output logic         rgb_enable,
   output logic         frame_ready
);

   // RAM write side from capture
   logic      wr_en;
   ram_addr_t wr_addr;
   rgb565_t   wr_data;
   // RAM read side, host read-back
   ram_addr_t read_addr;
   rgb565_t   rd_data;

   spi_cmd_if cmd_if ();

   spi_frame_rx spi_rx (
      .clk      (clk),
      .nrst     (nrst),
      .spi_sclk (som_sclk),
      .spi_cs_n (som_cs_n),
      .spi_mosi (som_mosi),
      .readback (rd_data),
      .spi_miso (som_miso),
      .cmd      (cmd_if.tx)
   );

   cmd_decoder decoder (
      .clk         (clk),
      .nrst        (nrst),
      .cmd         (cmd_if.rx),
      .rotation    (rotation),
      .driver_conf (driver_conf),
      .new_config  (new_config),
      .rgb_enable  (rgb_enable),
      .read_addr   (read_addr)
   );

   // Capture is gated by the host enable
   rgb_capture capture (
      .clk         (clk),
      .nrst        (nrst),
      .rgb         (rgb_d),
      .rgb_de      (rgb_de),
      .vsync       (rgb_vsync),
      .rgb_enable  (rgb_enable),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .frame_ready (frame_ready)
   );

   frame_ram main_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (read_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// File: design/pov_macros.svh
`ifndef POV_MACROS_SVH
`define POV_MACROS_SVH

// Frame geometry, kept small for simulation
`define POV_FRAME_PIXELS 16

// Frame RAM address width
`define POV_RAM_AW 16

// Longest command payload in bytes
`define POV_MAX_PAYLOAD 6

// Payload bytes required per opcode
`define POV_LEN_ROTATION 2
`define POV_LEN_DRIVER_CONF 6
`define POV_LEN_RGB_ENABLE 1
`define POV_LEN_READ_ADDR 2

`endif

// File: design/rgb_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "pov_macros.svh"

module rgb_capture import pixel_pkg::*; (
   input  wire logic clk,
   input  wire logic nrst,
   input  rgb888_t   rgb,
   input  wire logic rgb_de,
   input  wire logic vsync,
   input  wire logic rgb_enable,
   output logic      wr_en,
   output ram_addr_t wr_addr,
   output rgb565_t   wr_data,
   output logic      frame_ready
);

   logic     vsync_d;
   logic     vsync_rise;
   logic     take_pixel;
   pix_cnt_t pix_cnt;
   rgb565_t  pix565;

   // Top 5 red, top 6 green, top 5 blue
   assign pix565 = {rgb[23:19], rgb[15:10], rgb[7:3]};

   assign vsync_rise = vsync & ~vsync_d;

   // Frame full means later pixels are dropped
   assign take_pixel = rgb_de & rgb_enable
                       & (pix_cnt < pix_cnt_t'(`POV_FRAME_PIXELS));

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         vsync_d <= 1'b0;
      end else begin
         vsync_d <= vsync;
      end
   end

   // Pixel counter, restarted by each vsync
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         pix_cnt <= '0;
      end else if (vsync_rise) begin
         pix_cnt <= '0;
      end else if (take_pixel) begin
         pix_cnt <= pix_cnt + pix_cnt_t'(1);
      end
   end

   // Registered RAM write port
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         wr_en   <= 1'b0;
         wr_addr <= '0;
         wr_data <= '0;
      end else begin
         // vsync wins over a pixel in the same cycle
         wr_en <= take_pixel & ~vsync_rise;
         if (take_pixel) begin
            wr_addr <= ram_addr_t'(pix_cnt);
            wr_data <= pix565;
         end
      end
   end

   // Last pixel went into the RAM on the previous edge
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         frame_ready <= 1'b0;
      end else begin
         frame_ready <= wr_en & (wr_addr == ram_addr_t'(`POV_FRAME_PIXELS - 1));
      end
   end

   // Counter and write path must keep writes inside one frame
   a_wr_in_frame: assert property (@(posedge clk) disable iff (!nrst)
      wr_en |-> (wr_addr < ram_addr_t'(`POV_FRAME_PIXELS)));

endmodule

`default_nettype wire

// File: design/spi_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded SPI frame, receiver to decoder
interface spi_cmd_if import spi_pkg::*; ();

   cmd_opcode_t  opcode;
   cmd_payload_t payload;
   cmd_len_t     len;
   // Single-cycle strobe, other fields stable while high
   logic         valid;

   modport tx (output opcode, output payload, output len, output valid);

   modport rx (input opcode, input payload, input len, input valid);

endinterface

`default_nettype wire

// File: design/spi_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "pov_macros.svh"

module spi_frame_rx import spi_pkg::*, pixel_pkg::*; (
   input  wire logic clk,
   input  wire logic nrst,
   input  wire logic spi_sclk,
   input  wire logic spi_cs_n,
   input  wire logic spi_mosi,
   input  rgb565_t   readback,
   output logic      spi_miso,
   spi_cmd_if.tx     cmd
);

   // Two-flop synchronizers, bit 1 is the safe output
   logic [1:0] sclk_sync;
   logic [1:0] cs_sync;
   logic [1:0] mosi_sync;
   // Edge detect stage
   logic sclk_d;
   logic cs_d;
   logic sclk_rise;
   logic sclk_fall;
   logic cs_rise;
   logic cs_fall;

   rx_state_t    state;
   logic [2:0]   bit_cnt;
   spi_byte_t    byte_sr;
   spi_byte_t    next_byte;
   logic         have_op;
   cmd_opcode_t  opcode_q;
   cmd_payload_t payload_q;
   cmd_len_t     len_q;
   rgb565_t      miso_sr;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         sclk_sync <= '0;
         cs_sync   <= '0;
         mosi_sync <= '0;
         sclk_d    <= 1'b0;
         cs_d      <= 1'b0;
      end else begin
         sclk_sync <= {sclk_sync[0], spi_sclk};
         cs_sync   <= {cs_sync[0], spi_cs_n};
         mosi_sync <= {mosi_sync[0], spi_mosi};
         sclk_d    <= sclk_sync[1];
         cs_d      <= cs_sync[1];
      end
   end

   assign sclk_rise = sclk_sync[1] & ~sclk_d;
   assign sclk_fall = ~sclk_sync[1] & sclk_d;
   // cs_n is active low, so its fall opens a frame
   assign cs_fall   = ~cs_sync[1] & cs_d;
   assign cs_rise   = cs_sync[1] & ~cs_d;

   // MSB first, new bit enters at the bottom
   assign next_byte = {byte_sr[6:0], mosi_sync[1]};

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         state     <= rx_idle;
         bit_cnt   <= '0;
         byte_sr   <= '0;
         have_op   <= 1'b0;
         opcode_q  <= cmd_opcode_t'(8'h00);
         payload_q <= '0;
         len_q     <= '0;
         miso_sr   <= '0;
      end else begin
         case (state)
            rx_idle: begin
               if (cs_fall) begin
                  state     <= rx_shift;
                  bit_cnt   <= '0;
                  have_op   <= 1'b0;
                  payload_q <= '0;
                  len_q     <= '0;
                  // Word at the current read address goes out first
                  miso_sr   <= readback;
               end
            end
            rx_shift: begin
               if (cs_rise) begin
                  // Partial byte in byte_sr is simply dropped
                  state <= rx_done;
               end else if (sclk_rise) begin
                  byte_sr <= next_byte;
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     if (!have_op) begin
                        opcode_q <= cmd_opcode_t'(next_byte);
                        have_op  <= 1'b1;
                     end else if (len_q < cmd_len_t'(`POV_MAX_PAYLOAD)) begin
                        // Left-aligned, first payload byte lands on top
                        payload_q[8*(`POV_MAX_PAYLOAD-1-int'(len_q)) +: 8] <= next_byte;
                        len_q <= len_q + cmd_len_t'(1);
                     end
                  end
               end
               // Mode 0, host samples on rise so we change on fall
               if (sclk_fall) begin
                  miso_sr <= {miso_sr[14:0], 1'b0};
               end
            end
            rx_done: begin
               state <= rx_idle;
            end
            default: begin
               state <= rx_idle;
            end
         endcase
      end
   end

   assign spi_miso    = miso_sr[15];

   assign cmd.opcode  = opcode_q;
   assign cmd.payload = payload_q;
   assign cmd.len     = len_q;
   // No opcode byte, no command
   assign cmd.valid   = (state == rx_done) & have_op;

   // Each frame yields at most one strobe
   a_valid_single: assert property (@(posedge clk) disable iff (!nrst)
      cmd.valid |=> !cmd.valid);

endmodule

`default_nettype wire

// File: design/spi_pkg.sv
`default_nettype none

`include "pov_macros.svh"

package spi_pkg;

   // One byte on the SPI line
   typedef logic [7:0] spi_byte_t;

   // Command opcodes, first byte of a frame
   typedef enum logic [7:0] {
      op_rotation    = 8'd1,
      op_driver_conf = 8'd2,
      op_rgb_enable  = 8'd3,
      op_read_addr   = 8'd4
   } cmd_opcode_t;

   // Payload, first byte in the top bits
   typedef logic [`POV_MAX_PAYLOAD*8-1:0] cmd_payload_t;
   typedef logic [2:0] cmd_len_t;

   typedef logic [15:0] rotation_t;
   typedef logic [47:0] driver_conf_t;

   // Frame receiver FSM
   typedef enum logic [1:0] {rx_idle, rx_shift, rx_done} rx_state_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator, all output collected in sim.log
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module pov_ctrl_tb -o pov_sim \
   > sim.log 2>&1 \
   && ./obj_dir/pov_sim 2>&1 | tee -a sim.log \
   || { echo "Build or simulation did not complete, see sim.log"; exit 1; }
# Any failed check or a timeout leaves the fail message in the log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// File: src.f
+incdir+design
design/spi_pkg.sv
design/pixel_pkg.sv
design/spi_cmd_if.sv
design/spi_frame_rx.sv
design/cmd_decoder.sv
design/rgb_capture.sv
design/frame_ram.sv
design/pov_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/pov_ctrl_tb.sv

// File: testbench/pov_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pov_macros.svh"

module pov_ctrl_tb import spi_pkg::*, pixel_pkg::*; ();

   localparam int unsigned RAND_SEED = 32'habdd43f5;
   // sclk half period in clk cycles
   localparam int SCLK_HALF   = 4;
   localparam int SETTLE_CLKS = 10;
   localparam int NUM_ENTRIES = 6;
   // Enable, disable and two rounds of four read-back pairs
   localparam int OTHER_FRAMES = 18;
   // Longest frame is the opcode plus full payload with setup and settle time
   localparam int FRAME_CLKS  = 2 * SCLK_HALF * 8 * (1 + `POV_MAX_PAYLOAD)
                                + 2 * SCLK_HALF + SETTLE_CLKS + 2;
   localparam int PIXEL_CLKS  = 2 * 4 * `POV_FRAME_PIXELS;
   localparam int WATCHDOG_CLKS = 2 * ((NUM_ENTRIES + OTHER_FRAMES) * FRAME_CLKS
                                       + PIXEL_CLKS + 50);

   // One SPI command and the display state expected after it
   typedef struct packed {
      spi_byte_t    opcode;
      cmd_payload_t payload;
      logic [7:0]   nbits;
      rotation_t    exp_rot;
      driver_conf_t exp_conf;
      logic         exp_pulse;
   } cmd_entry_t;

   logic         clk;
   logic         nrst;
   logic         som_sclk;
   logic         som_cs_n;
   logic         som_mosi;
   logic         som_miso;
   rgb888_t      rgb_d;
   logic         rgb_de;
   logic         rgb_vsync;
   rotation_t    rotation;
   driver_conf_t driver_conf;
   logic         new_config;
   logic         rgb_enable;
   logic         frame_ready;

   cmd_entry_t cmd_table [NUM_ENTRIES];
   string      entry_name [NUM_ENTRIES];
   rgb888_t    sent_px [`POV_FRAME_PIXELS];
   rgb565_t    stored_px [`POV_FRAME_PIXELS];
   int         rb_idx [4];
   int         config_pulses = 0;
   int         ready_pulses = 0;
   int         check_cnt = 0;
   int         err_cnt = 0;

   tb_clock_gen clock_gen (
      .clk  (clk),
      .nrst (nrst)
   );

   pov_ctrl_top pov_ctrl_top_i (
      .clk         (clk),
      .nrst        (nrst),
      .som_sclk    (som_sclk),
      .som_cs_n    (som_cs_n),
      .som_mosi    (som_mosi),
      .som_miso    (som_miso),
      .rgb_d       (rgb_d),
      .rgb_de      (rgb_de),
      .rgb_vsync   (rgb_vsync),
      .rotation    (rotation),
      .driver_conf (driver_conf),
      .new_config  (new_config),
      .rgb_enable  (rgb_enable),
      .frame_ready (frame_ready)
   );

   // Pulse counters see each output before the edge that updates it
   always @(posedge clk) begin
      if (new_config === 1'b1) begin
         config_pulses <= config_pulses + 1;
      end
      if (frame_ready === 1'b1) begin
         ready_pulses <= ready_pulses + 1;
      end
   end

   task automatic check_rotation(input string name, input rotation_t got, input rotation_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_conf(input string name, input driver_conf_t got,
                             input driver_conf_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pixel(input string name, input rgb565_t got, input rgb565_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      check_cnt++;
      if (got != exp) begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // Keep the top 5, 6 and 5 bits of red, green and blue
   function automatic rgb565_t to_rgb565(input rgb888_t px);
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
      red   = px[23:16];
      green = px[15:8];
      blue  = px[7:0];
      return {red[7:3], green[7:2], blue[7:3]};
   endfunction

   // Sends a mode 0 frame MSB first and returns the first 16 MISO bits
   task automatic spi_transfer(input spi_byte_t opcode, input cmd_payload_t payload,
                               input int nbits, output rgb565_t miso_word);
      logic [55:0] line_bits;
      int          i;
      line_bits = {opcode, payload};
      miso_word = '0;
      @(negedge clk);
      som_cs_n = 1'b0;
      som_sclk = 1'b0;
      // Room for the DUT to load its read-back word
      repeat (SCLK_HALF) @(negedge clk);
      for (i = 0; i < nbits; i++) begin
         som_mosi = line_bits[55 - i];
         repeat (SCLK_HALF) @(negedge clk);
         // Host samples MISO at the rising sclk
         if (i < 16) begin
            miso_word[15 - i] = som_miso;
         end
         som_sclk = 1'b1;
         repeat (SCLK_HALF) @(negedge clk);
         som_sclk = 1'b0;
      end
      repeat (SCLK_HALF) @(negedge clk);
      som_cs_n = 1'b1;
      som_mosi = 1'b0;
   endtask

   task automatic pulse_vsync();
      @(negedge clk);
      rgb_vsync = 1'b1;
      @(negedge clk);
      rgb_vsync = 1'b0;
   endtask

   // One frame of random pixels with rgb_de low for 0 to 2 cycles between them
   task automatic feed_frame();
      int n;
      int gap;
      for (n = 0; n < `POV_FRAME_PIXELS; n++) begin
         gap = $urandom_range(2, 0);
         repeat (gap) @(negedge clk);
         sent_px[n] = rgb888_t'($urandom);
         rgb_d  = sent_px[n];
         rgb_de = 1'b1;
         @(negedge clk);
         rgb_de = 1'b0;
      end
      repeat (4) @(negedge clk);
   endtask

   // Point the RAM read port at k and fetch the word with a dummy frame
   task automatic read_back(input int k, output rgb565_t word);
      ram_addr_t addr;
      rgb565_t   unused;
      addr = ram_addr_t'(k);
      spi_transfer(spi_byte_t'(op_read_addr), {addr, 32'h0}, 24, unused);
      repeat (SETTLE_CLKS) @(negedge clk);
      // Unknown opcode 0x00 changes nothing
      spi_transfer(8'h00, '0, 16, word);
      repeat (SETTLE_CLKS) @(negedge clk);
   endtask

   task automatic fill_cmd_table();
      logic [31:0]  rand_hi;
      logic [31:0]  rand_lo;
      driver_conf_t conf;
      rotation_t    rot2;
      rand_hi = $urandom;
      rand_lo = $urandom;
      conf    = {rand_hi[15:0], rand_lo};
      rot2    = rotation_t'($urandom);
      cmd_table[0] = '{spi_byte_t'(op_rotation), {16'h1234, 32'h0}, 8'd24,
                       16'h1234, '0, 1'b0};
      entry_name[0] = "rotation";
      cmd_table[1] = '{spi_byte_t'(op_driver_conf), conf, 8'd56, 16'h1234, conf, 1'b1};
      entry_name[1] = "driver conf";
      // Bad frames below must leave the state alone
      cmd_table[2] = '{spi_byte_t'(op_rotation), {24'habcdef, 24'h0}, 8'd32,
                       16'h1234, conf, 1'b0};
      entry_name[2] = "rotation with 3 bytes";
      cmd_table[3] = '{8'h7f, {16'h5555, 32'h0}, 8'd24, 16'h1234, conf, 1'b0};
      entry_name[3] = "unknown opcode";
      cmd_table[4] = '{spi_byte_t'(op_rotation), '0, 8'd4, 16'h1234, conf, 1'b0};
      entry_name[4] = "4-bit frame";
      cmd_table[5] = '{spi_byte_t'(op_rotation), {rot2, 32'h0}, 8'd24, rot2, conf, 1'b0};
      entry_name[5] = "second rotation";
   endtask

   initial begin : timeout_guard
      repeat (WATCHDOG_CLKS) @(posedge clk);
      $display("Timeout: run did not end within %0d clock cycles", WATCHDOG_CLKS);
      $display("Checks failed");
      $finish;
   end

   initial begin : main_seq
      int          e;
      int          j;
      int          start_pulses;
      rgb565_t     word;
      rgb565_t     unused;
      som_sclk  = 1'b0;
      som_cs_n  = 1'b1;
      som_mosi  = 1'b0;
      rgb_d     = '0;
      rgb_de    = 1'b0;
      rgb_vsync = 1'b0;
      void'($urandom(RAND_SEED));
      fill_cmd_table();
      rb_idx[0] = 0;
      rb_idx[1] = 5;
      rb_idx[2] = `POV_FRAME_PIXELS - 1;
      rb_idx[3] = int'($urandom_range(`POV_FRAME_PIXELS - 1, 0));

      wait (nrst === 1'b1);
      @(negedge clk);
      // Everything idle out of reset
      check_rotation("rotation after reset", rotation, '0);
      check_conf("driver_conf after reset", driver_conf, '0);
      check_bit("new_config after reset", new_config, 1'b0);
      check_bit("rgb_enable after reset", rgb_enable, 1'b0);
      check_bit("frame_ready after reset", frame_ready, 1'b0);
      check_bit("som_miso after reset", som_miso, 1'b0);

      // Command table
      for (e = 0; e < NUM_ENTRIES; e++) begin
         start_pulses = config_pulses;
         spi_transfer(cmd_table[e].opcode, cmd_table[e].payload,
                      int'(cmd_table[e].nbits), unused);
         repeat (SETTLE_CLKS) @(negedge clk);
         check_rotation({entry_name[e], " rotation"}, rotation, cmd_table[e].exp_rot);
         check_conf({entry_name[e], " driver_conf"}, driver_conf, cmd_table[e].exp_conf);
         check_count({entry_name[e], " new_config pulses"}, config_pulses - start_pulses,
                     int'(cmd_table[e].exp_pulse));
      end

      // Capture one frame
      spi_transfer(spi_byte_t'(op_rgb_enable), {8'h01, 40'h0}, 16, unused);
      repeat (SETTLE_CLKS) @(negedge clk);
      check_bit("rgb_enable after enable", rgb_enable, 1'b1);
      start_pulses = ready_pulses;
      pulse_vsync();
      feed_frame();
      check_count("frame_ready pulses", ready_pulses - start_pulses, 1);
      for (j = 0; j < `POV_FRAME_PIXELS; j++) begin
         stored_px[j] = to_rgb565(sent_px[j]);
      end

      for (j = 0; j < 4; j++) begin
         read_back(rb_idx[j], word);
         check_pixel($sformatf("read-back pixel %0d", rb_idx[j]), word, stored_px[rb_idx[j]]);
      end

      // With capture off the RAM keeps the first frame
      spi_transfer(spi_byte_t'(op_rgb_enable), '0, 16, unused);
      repeat (SETTLE_CLKS) @(negedge clk);
      check_bit("rgb_enable after disable", rgb_enable, 1'b0);
      start_pulses = ready_pulses;
      pulse_vsync();
      feed_frame();
      check_count("frame_ready pulses while disabled", ready_pulses - start_pulses, 0);
      for (j = 0; j < 4; j++) begin
         read_back(rb_idx[j], word);
         check_pixel($sformatf("old pixel %0d", rb_idx[j]), word, stored_px[rb_idx[j]]);
      end

      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset for the testbench
module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic nrst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release on a falling edge, away from the DUT's sampling edge
   initial begin
      nrst = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nrst = 1'b1;
   end

endmodule

`default_nettype wire
